// File: Makefile
# Verilator flow for the Hamming window front end

VERILATOR  ?= verilator
FILELIST   ?= build.f
TOP        ?= hamming_window_tb
LINT_TOP   ?= hamming_window_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= >>> PASS
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

RTL_SRCS := $(shell grep '^logic/' $(FILELIST))
ALL_SRCS := $(shell grep '\.s\?v$$' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(ALL_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -- "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
logic/window_pkg.sv
logic/window_ctrl.sv
logic/frame_buffer.sv
logic/cordic_cos.sv
logic/window_mult.sv
logic/hamming_window_top.sv
test/tb_clock.sv
test/hamming_window_tb.sv

// File: logic/cordic_cos.sv
`timescale 1ns/1ns

module cordic_cos
  import window_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  phase_t  phase,
  input  rd_tag_t tag_in,
  input  logic    rect_mode,
  output coeff_t  coeff,
  output rd_tag_t tag_out
);

  typedef logic signed [17:0] cdata_t;  // Q15 with headroom for gain overshoot
  typedef logic signed [16:0] cang_t;   // Residual angle

  cdata_t             x_q   [CORDIC_STAGES];
  cdata_t             y_q   [CORDIC_STAGES];
  cang_t              z_q   [CORDIC_STAGES];
  logic               neg_q [CORDIC_STAGES];
  rd_tag_t            tag_q [CORDIC_STAGES];
  cang_t              z_fold;
  logic               neg_fold;
  cdata_t             cos_v;
  logic signed [34:0] prod;
  logic signed [19:0] ham;

  // Map to [0, pi/2] and remember the sign of the cosine
  always_comb begin
    case (phase[15:14])
      2'b00: begin
        z_fold   = cang_t'({1'b0, phase});
        neg_fold = 1'b0;
      end
      2'b01: begin
        z_fold   = cang_t'(17'h08000 - {1'b0, phase});  // pi - a
        neg_fold = 1'b1;
      end
      2'b10: begin
        z_fold   = cang_t'({1'b0, phase} - 17'h08000);  // a - pi
        neg_fold = 1'b1;
      end
      default: begin
        z_fold   = cang_t'(17'h10000 - {1'b0, phase});  // 2*pi - a
        neg_fold = 1'b0;
      end
    endcase
  end

  for (genvar i = 0; i < CORDIC_STAGES; i++) begin : g_stage
    cdata_t  x_in;
    cdata_t  y_in;
    cang_t   z_in;
    cang_t   atan;
    logic    neg_in;
    rd_tag_t tag_s;

    if (i == 0) begin : g_first
      assign x_in   = cdata_t'(CORDIC_GAIN);  // Prescaled so x ends at cos
      assign y_in   = '0;
      assign z_in   = z_fold;
      assign neg_in = neg_fold;
      assign tag_s  = tag_in;
    end else begin : g_rest
      assign x_in   = x_q[i-1];
      assign y_in   = y_q[i-1];
      assign z_in   = z_q[i-1];
      assign neg_in = neg_q[i-1];
      assign tag_s  = tag_q[i-1];
    end

    assign atan = cang_t'(CORDIC_ATAN[i]);

    always_ff @(posedge clk) begin
      if (z_in[16]) begin  // Rotate clockwise
        x_q[i] <= x_in + (y_in >>> i);
        y_q[i] <= y_in - (x_in >>> i);
        z_q[i] <= z_in + atan;
      end else begin
        x_q[i] <= x_in - (y_in >>> i);
        y_q[i] <= y_in + (x_in >>> i);
        z_q[i] <= z_in - atan;
      end
      neg_q[i] <= neg_in;
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        tag_q[i] <= '0;
      end else begin
        tag_q[i] <= tag_s;
      end
    end
  end

  // w = A0 - A1 * cos, rounded half up
  always_comb begin
    cos_v = neg_q[CORDIC_STAGES-1] ? -x_q[CORDIC_STAGES-1] : x_q[CORDIC_STAGES-1];
    prod  = $signed({1'b0, HAM_A1}) * cos_v;
    ham   = $signed({4'b0, HAM_A0}) - 20'((prod + 35'sd16384) >>> 15);
  end

  always_ff @(posedge clk) begin
    if (rect_mode) begin
      coeff <= 16'h7FFF;
    end else if (ham < 0) begin
      coeff <= '0;
    end else if (ham > 20'sd32767) begin
      coeff <= 16'h7FFF;  // Peak can round to 1.0
    end else begin
      coeff <= coeff_t'(ham[15:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_out <= '0;
    end else begin
      tag_out <= tag_q[CORDIC_STAGES-1];
    end
  end

endmodule

// File: logic/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer
  import window_pkg::*;
(
  input  logic    clk,
  input  logic    wr_en,
  input  logic    wr_bank,
  input  idx_t    wr_addr,
  input  sample_t wr_data,
  input  logic    rd_bank,
  input  idx_t    rd_addr,
  output sample_t rd_data
);

  sample_t mem [2*FRAME_LEN];  // Bank select is the top address bit

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[{wr_bank, wr_addr[$clog2(FRAME_LEN)-1:0]}] <= wr_data;
    end
  end

  // Single registered read; the controller already offsets the address
  // by the CORDIC depth so rd_data lands with its coefficient
  always_ff @(posedge clk) begin
    rd_data <= mem[{rd_bank, rd_addr[$clog2(FRAME_LEN)-1:0]}];
  end

  a_wr_range: assert property (@(posedge clk)
    wr_en |-> (wr_addr < idx_t'(FRAME_LEN)));

endmodule

// File: logic/hamming_window_top.sv
`timescale 1ns/1ns

module hamming_window_top
  import window_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  sample_t  sample_in,
  input  logic     sample_valid,
  output sample_t  sample_out,
  output logic     out_valid,
  output logic     out_last
);

  logic    wr_en;
  logic    wr_bank;
  idx_t    wr_addr;
  logic    rd_bank;
  idx_t    rd_addr;
  sample_t rd_data;
  phase_t  phase;
  rd_tag_t ctrl_tag;   // Issued with the phase
  rd_tag_t coeff_tag;  // Aligned with coeff
  logic    rect_mode;
  coeff_t  coeff;

  window_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .sample_valid (sample_valid),
    .wr_en        (wr_en),
    .wr_bank      (wr_bank),
    .wr_addr      (wr_addr),
    .rd_bank      (rd_bank),
    .rd_addr      (rd_addr),
    .phase        (phase),
    .tag          (ctrl_tag),
    .rect_mode    (rect_mode)
  );

  frame_buffer u_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_bank (wr_bank),
    .wr_addr (wr_addr),
    .wr_data (sample_in),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  cordic_cos u_cordic (
    .clk       (clk),
    .rst       (rst),
    .phase     (phase),
    .tag_in    (ctrl_tag),
    .rect_mode (rect_mode),
    .coeff     (coeff),
    .tag_out   (coeff_tag)
  );

  window_mult u_mult (
    .clk        (clk),
    .rst        (rst),
    .sample     (rd_data),
    .coeff      (coeff),
    .tag        (coeff_tag),
    .sample_out (sample_out),
    .out_valid  (out_valid),
    .out_last   (out_last)
  );

endmodule

// File: logic/window_ctrl.sv
`timescale 1ns/1ns

module window_ctrl
  import window_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  logic     sample_valid,
  output logic     wr_en,
  output logic     wr_bank,
  output idx_t     wr_addr,
  output logic     rd_bank,
  output idx_t     rd_addr,
  output phase_t   phase,
  output rd_tag_t  tag,
  output logic     rect_mode
);

  typedef enum logic [1:0] {IDLE, FILL, DRAIN} state_t;

  state_t      state;
  logic        ctrl_en;
  logic        overrun;
  logic [15:0] frame_cnt;
  logic [1:0]  full;       // Bank holds an unread frame
  idx_t        fill_cnt;
  idx_t        drain_idx;
  phase_t      phase_acc;
  logic        apb_wr;
  logic        frame_done;
  logic        drain_end;
  logic        drop;
  logic        start_drain;

  assign apb_wr      = apb_req.psel & apb_req.penable & apb_req.pwrite;
  assign wr_en       = sample_valid & ctrl_en;
  assign wr_addr     = fill_cnt;
  assign frame_done  = wr_en & (fill_cnt == idx_t'(FRAME_LEN - 1));
  assign drain_end   = (state == DRAIN) & (drain_idx == idx_t'(PAD_LEN - 1));
  assign drop        = frame_done & full[~wr_bank] & ~drain_end;  // Other bank still draining
  assign start_drain = frame_done & ~drop;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_en   <= 1'b0;
      rect_mode <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      if (apb_wr && apb_req.paddr == REG_CTRL) begin
        ctrl_en   <= apb_req.pwdata[0];
        rect_mode <= apb_req.pwdata[1];
      end
      if (drop) begin
        overrun <= 1'b1;
      end else if (apb_wr && apb_req.paddr == REG_STATUS && apb_req.pwdata[16]) begin
        overrun <= 1'b0;  // Write-one-to-clear
      end
    end
  end

  always_comb begin
    apb_rsp        = '0;
    apb_rsp.pready = 1'b1;  // Zero wait states
    case (apb_req.paddr)
      REG_CTRL:   apb_rsp.prdata = {30'd0, rect_mode, ctrl_en};
      REG_STATUS: apb_rsp.prdata = {15'd0, overrun, frame_cnt};
      default:    apb_rsp.pslverr = apb_req.psel & apb_req.penable;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      fill_cnt  <= '0;
      drain_idx <= '0;
      phase_acc <= '0;
      wr_bank   <= 1'b0;
      rd_bank   <= 1'b0;
      full      <= '0;
      frame_cnt <= '0;
      tag       <= '0;
    end else begin
      if (!ctrl_en || frame_done) begin
        fill_cnt <= '0;  // Disable drops a partial frame
      end else if (wr_en) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (start_drain) begin
        wr_bank <= ~wr_bank;
        rd_bank <= wr_bank;
      end
      full <= (full & ~({1'b0, drain_end} << rd_bank)) | ({1'b0, start_drain} << wr_bank);
      if (drain_end) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
      case (state)
        IDLE, FILL: state <= start_drain ? DRAIN : (ctrl_en ? FILL : IDLE);
        DRAIN: begin
          if (drain_end) begin
            state <= start_drain ? DRAIN : (ctrl_en ? FILL : IDLE);
          end
        end
        default: state <= IDLE;
      endcase
      if (start_drain) begin
        drain_idx <= '0;
        phase_acc <= '0;
      end else if (state == DRAIN) begin
        drain_idx <= drain_idx + 1'b1;
        phase_acc <= phase_acc + PHASE_STEP;
      end
      if (state == DRAIN) begin
        tag <= '{pad: drain_idx[8], last: drain_end, valid: 1'b1};
      end else begin
        tag <= '0;
      end
    end
  end

  // Buffer read trails the phase by the CORDIC depth so data meets its coefficient
  always_ff @(posedge clk) begin
    phase   <= drain_idx[8] ? '0 : phase_acc;
    rd_addr <= drain_idx - idx_t'(CORDIC_STAGES);
  end

  // Drained bank still holds its frame while the write bank is free
  a_bank_split: assert property (@(posedge clk) disable iff (rst)
    (state == DRAIN) |-> (full[rd_bank] && !full[wr_bank]));

  a_apb_penable: assert property (@(posedge clk) disable iff (rst)
    apb_req.penable |-> apb_req.psel);

endmodule

// File: logic/window_mult.sv
`timescale 1ns/1ns

module window_mult
  import window_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  sample_t sample,
  input  coeff_t  coeff,
  input  rd_tag_t tag,
  output sample_t sample_out,
  output logic    out_valid,
  output logic    out_last
);

  logic signed [32:0] prod;
  logic signed [17:0] rounded;
  sample_t            sat;

  always_comb begin
    prod    = sample * $signed({1'b0, coeff});  // Coeff is unsigned Q15
    rounded = 18'((prod + 33'sd16384) >>> 15);  // Round half up
    if (rounded > 18'sd32767) begin
      sat = 16'sh7FFF;
    end else if (rounded < -18'sd32768) begin
      sat = 16'sh8000;
    end else begin
      sat = rounded[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sample_out <= '0;
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
    end else begin
      sample_out <= tag.pad ? '0 : sat;  // Zero padding for the FFT
      out_valid  <= tag.valid;
      out_last   <= tag.last;
    end
  end

  // Last flag comes from the controller through the whole CORDIC pipe
  a_last_valid: assert property (@(posedge clk) disable iff (rst)
    out_last |-> out_valid);

endmodule

// File: logic/window_pkg.sv
package window_pkg;

  typedef logic signed [15:0] sample_t;  // Q15 input sample
  typedef logic [15:0]        coeff_t;   // Q15 weight, 0x7FFF ~ 1.0
  typedef logic [15:0]        phase_t;   // Binary angle, full scale = 2*pi
  typedef logic [8:0]         idx_t;     // Index over the padded frame

  localparam int     FRAME_LEN  = 256;
  localparam int     PAD_LEN    = 512;
  localparam phase_t PHASE_STEP = 16'd257;  // ~65536 / (FRAME_LEN - 1)

  localparam coeff_t HAM_A0        = 16'd17695;  // 0.54
  localparam coeff_t HAM_A1        = 16'd15073;  // 0.46
  localparam int     CORDIC_STAGES = 12;
  localparam coeff_t CORDIC_GAIN   = 16'h4DBA;   // 1/K = 0.6073

  // atan(2^-i) in binary-angle units
  localparam logic [0:CORDIC_STAGES-1][15:0] CORDIC_ATAN = {
    16'd8192, 16'd4836, 16'd2555, 16'd1297,
    16'd651,  16'd326,  16'd163,  16'd81,
    16'd41,   16'd20,   16'd10,   16'd5
  };

  localparam int PIPE_LAT = 15;  // Last accepted sample to first output

  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_STATUS = 4'h4;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic pad;    // Zero-padding slot
    logic last;   // Final value of the padded frame
    logic valid;
  } rd_tag_t;

endpackage

// File: test/hamming_window_tb.sv
`timescale 1ns/1ns

module hamming_window_tb
  import window_pkg::*;
();

  localparam int  TIMEOUT = 2000;  // Cycles per wait loop
  localparam real PI      = 3.14159265358979;

  logic     clk;
  logic     rst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  sample_t  sample_in;
  logic     sample_valid;
  sample_t  sample_out;
  logic     out_valid;
  logic     out_last;

  integer seed = 98;
  longint cyc = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  bit     timed_out = 0;
  int     last_cnt = 0;
  int     out_q[$];
  bit     last_q[$];
  longint cyc_q[$];
  int     sent_q[$];
  longint accept_q[$];

  tb_clock u_clock (.clk(clk));

  hamming_window_top hamming_window_top_inst (
    .clk          (clk),
    .rst          (rst),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .sample_out   (sample_out),
    .out_valid    (out_valid),
    .out_last     (out_last)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // Outputs settle after the rising edge, so capture on the falling one
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      out_q.push_back(int'(sample_out));
      last_q.push_back(out_last);
      cyc_q.push_back(cyc);
      if (out_last) last_cnt++;
    end
  end

  task automatic check_value(string name, longint actual, longint expected, int tol);
    longint diff;
    checks++;
    diff = (actual > expected) ? actual - expected : expected - actual;
    if (diff > tol) begin
      errors++;
      $display("error at %0t ns: %s actual %0d expected %0d", $time, name, actual, expected);
    end
  endtask

  // Q15 window weight of index k, 0.54 - 0.46*cos(theta)
  function automatic int ham_coeff(int k);
    real w;
    int  c;
    w = 0.54 - 0.46 * $cos(2.0 * PI * real'((k * 257) % 65536) / 65536.0);
    c = $rtoi(w * 32768.0 + 0.5);
    return (c > 32767) ? 32767 : c;
  endfunction

  function automatic int scale_round(int s, int c);
    longint p;
    p = (longint'(s) * c + 16384) >>> 15;  // Round half up
    if (p > 32767) p = 32767;
    if (p < -32768) p = -32768;
    return int'(p);
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    #5;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b0;
    out_q.delete();
    last_q.delete();
    cyc_q.delete();
    sent_q.delete();
    accept_q.delete();
    last_cnt = 0;
  endtask

  task automatic apb_write(logic [3:0] addr, logic [31:0] data);
    @(posedge clk);
    #5;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    #5;
    apb_req.penable = 1'b1;
    @(posedge clk);
    #5;
    apb_req = '0;
  endtask

  task automatic apb_read(logic [3:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    #5;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge clk);
    #5;
    apb_req.penable = 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    check_value("pready", apb_rsp.pready, 1, 0);
    @(posedge clk);
    #5;
    apb_req = '0;
  endtask

  // One sample every stride cycles, frames back to back
  task automatic send_frames(int n, int stride, int amp);
    int i;
    int s;
    for (i = 0; i < n * FRAME_LEN; i++) begin
      @(posedge clk);
      #5;
      s = $random(seed) % amp;
      sample_in    = sample_t'(s);
      sample_valid = 1'b1;
      sent_q.push_back(s);
      accept_q.push_back(cyc + 1);
      repeat (stride - 1) begin
        @(posedge clk);
        #5;
        sample_valid = 1'b0;
      end
    end
    @(posedge clk);
    #5;
    sample_valid = 1'b0;
  endtask

  task automatic wait_frames(int n);
    int t;
    t = 0;
    while (last_cnt < n && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (last_cnt < n) begin
      errors++;
      timed_out = 1;
      $display("timeout: only %0d of %0d frames came out within %0d cycles", last_cnt, n, TIMEOUT);
    end
    repeat (20) @(posedge clk);  // Room for any stray output
  endtask

  task automatic check_frame(int f, int base, bit rect, int tol);
    int k;
    int expected;
    if (out_q.size() < base + PAD_LEN) return;
    for (k = 0; k < PAD_LEN; k++) begin
      if (k < FRAME_LEN) begin
        expected = scale_round(sent_q[f * FRAME_LEN + k], rect ? 32767 : ham_coeff(k));
        check_value("sample_out", out_q[base + k], expected, tol);
      end else begin
        check_value("sample_out", out_q[base + k], 0, 0);  // Padding
      end
      check_value("out_last", last_q[base + k], k == PAD_LEN - 1, 0);
      if (k > 0) check_value("out_valid_gap", cyc_q[base + k] - cyc_q[base + k - 1], 1, 0);
    end
  endtask

  task automatic finish_test(string name, int err0);
    tests_run++;
    $display("test %s done with %0d errors", name, errors - err0);
  endtask

  task automatic registers_after_reset();
    logic [31:0] rd;
    logic        err;
    int          err0;
    err0 = errors;
    reset_dut();
    check_value("out_valid", out_valid, 0, 0);
    check_value("out_last", out_last, 0, 0);
    apb_read(REG_CTRL, rd, err);
    check_value("ctrl", rd, 0, 0);
    apb_read(REG_STATUS, rd, err);
    check_value("status", rd, 0, 0);
    apb_write(REG_CTRL, 32'h3);
    apb_read(REG_CTRL, rd, err);
    check_value("ctrl", rd, 3, 0);
    apb_write(REG_CTRL, 32'h0);
    apb_write(REG_STATUS, 32'h1_0000);
    apb_read(REG_STATUS, rd, err);
    check_value("status", rd, 0, 0);
    check_value("pslverr", err, 0, 0);
    apb_read(4'h8, rd, err);
    check_value("pslverr", err, 1, 0);
    finish_test("registers", err0);
  endtask

  // Small amplitude keeps the CORDIC error inside the 4 LSB tolerance
  task automatic hamming_frame();
    logic [31:0] rd;
    logic        err;
    int          err0;
    err0 = errors;
    reset_dut();
    apb_write(REG_CTRL, 32'h1);
    send_frames(1, 1, 4096);
    wait_frames(1);
    if (timed_out) return;
    check_value("output_count", out_q.size(), PAD_LEN, 0);
    check_frame(0, 0, 1'b0, 4);
    apb_read(REG_STATUS, rd, err);
    check_value("status", rd, 1, 0);
    finish_test("hamming_frame", err0);
  endtask

  task automatic rect_frame();
    int err0;
    err0 = errors;
    reset_dut();
    apb_write(REG_CTRL, 32'h3);
    send_frames(1, 1, 32768);
    wait_frames(1);
    if (timed_out) return;
    check_value("output_count", out_q.size(), PAD_LEN, 0);
    check_frame(0, 0, 1'b1, 0);
    finish_test("rect_frame", err0);
  endtask

  task automatic back_to_back();
    logic [31:0] rd;
    logic        err;
    int          err0;
    err0 = errors;
    reset_dut();
    apb_write(REG_CTRL, 32'h1);
    send_frames(2, 3, 4096);  // Each fill outlasts the other drain
    wait_frames(2);
    if (timed_out) return;
    check_value("output_count", out_q.size(), 2 * PAD_LEN, 0);
    check_frame(0, 0, 1'b0, 4);
    check_frame(1, PAD_LEN, 1'b0, 4);
    apb_read(REG_STATUS, rd, err);
    check_value("status", rd, 2, 0);
    finish_test("back_to_back", err0);
  endtask

  task automatic overrun_drop();
    logic [31:0] rd;
    logic        err;
    int          err0;
    err0 = errors;
    reset_dut();
    apb_write(REG_CTRL, 32'h1);
    send_frames(3, 1, 4096);  // Second frame lands while the first drains
    wait_frames(2);
    if (timed_out) return;
    apb_read(REG_STATUS, rd, err);
    check_value("overrun", rd[16], 1, 0);
    check_value("frame_cnt_lags", rd[15:0] < 16'd3, 1, 0);
    apb_write(REG_STATUS, 32'h1_0000);
    apb_read(REG_STATUS, rd, err);
    check_value("overrun", rd[16], 0, 0);
    finish_test("overrun", err0);
  endtask

  task automatic drain_latency();
    int err0;
    err0 = errors;
    reset_dut();
    apb_write(REG_CTRL, 32'h1);
    send_frames(1, 2, 4096);
    wait_frames(1);
    if (timed_out) return;
    check_value("output_count", out_q.size(), PAD_LEN, 0);
    check_value("latency", cyc_q[0] - accept_q[FRAME_LEN - 1], PIPE_LAT, 0);
    finish_test("latency", err0);
  endtask

  initial begin
    rst          = 1'b1;
    apb_req      = '0;
    sample_in    = '0;
    sample_valid = 1'b0;
    registers_after_reset();
    if (!timed_out) hamming_frame();
    if (!timed_out) rect_frame();
    if (!timed_out) back_to_back();
    if (!timed_out) overrun_drop();
    if (!timed_out) drain_latency();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule
